/* hw/lzw_pkg.sv */
// Shared widths, constants and control structs of the LZW control unit, imported by every RTL file
`default_nettype none

package lzw_pkg;

  localparam int IO_ADDR_W = 12;                    // IO and output RAM address width
  localparam int CODE_W = 13;                       // Dictionary code width

  localparam logic [CODE_W-1:0] FIRST_CODE = 13'd256; // First code after the 256 literals

  typedef struct packed {
    logic gen_hash;                                 // Start a hash
    logic recal_hash;                               // Rehash after collision
    logic shift_char;                               // Char reg into string reg
    logic mux_code_val;                             // Code value into string reg
  } hash_cmd_t;

  typedef struct packed {
    logic not_in_mem;                               // Entry free, new code needed
    logic in_code_mem;                              // String found in code memory
    logic match;                                    // Dictionary match
    logic collis;                                   // Hash collision
  } hash_rsp_t;

  typedef struct packed {
    logic write_data;                               // Load code into output reg
    logic read_data;                                // Pop a byte from output reg
    logic write_sp;                                 // Load special end code
  } oreg_cmd_t;

  // Port A enables of the code value, append char and prefix code RAMs
  typedef struct packed {
    logic ena_cvram;                                // CV RAM port A enable
    logic wea_cvram;                                // CV RAM port A write
    logic wea_acram;                                // Append char RAM write
    logic wea_pcram;                                // Prefix code RAM write
  } dict_en_t;

  typedef struct packed {
    dict_en_t en;                                   // From the sequencer
    logic [CODE_W-1:0] wr_cvdataa;                  // Next free code
  } dict_wr_t;

  typedef struct packed {
    logic en;                                       // Port B enable
    logic we;                                       // Port B write enable
  } ram_ctl_t;

endpackage

`default_nettype wire

/* hw/lzw_seq_fsm.sv */
// One-hot sequencer of the LZW control unit: CV RAM sweep, compression loop, output drain and flush
`timescale 1ns/1ps
`default_nettype none

module lzw_seq_fsm
  import lzw_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      init_cr,        // Start CV RAM sweep
  input  wire logic      init_lzw,       // Start compression
  input  wire hash_rsp_t hash_rsp,       // Hash unit result
  input  wire logic      valid_dcnt,     // More bytes left in output reg
  input  wire logic      tc_outreg,      // Output reg empty
  input  wire logic      io_end,         // Last character reached
  input  wire logic      cv_end,         // Sweep address all ones
  output hash_cmd_t      hash_cmd,
  output oreg_cmd_t      oreg_cmd,
  output dict_en_t       dict_ctl,
  output ram_ctl_t       io_ram,
  output ram_ctl_t       out_ram,
  output ram_ctl_t       cv_ram,
  output logic           inc_io,         // IO address +1
  output logic           inc_out,        // Output address +1
  output logic           inc_cv,         // Sweep address +1, delayed downstream
  output logic           clr_cv,         // Sweep address clear
  output logic           inc_code,       // Next code +1
  output logic           run_done,       // Early done, reloads next code
  output logic           done_cr,
  output logic           lzw_done
);

  localparam int S_IDLE    = 0;          // Wait for init_cr
  localparam int S_INIT_CR = 1;          // CV RAM sweep
  localparam int S_WT_LZW  = 2;          // Wait for init_lzw
  localparam int S_WT_D1   = 3;          // First char arrives
  localparam int S_RD_CHR  = 4;          // Read next char
  localparam int S_WT_D2   = 5;          // Next char arrives
  localparam int S_GEN     = 6;          // Hash running
  localparam int S_WT_HASH = 7;
  localparam int S_WT_RH   = 8;          // Wait after recalculate
  localparam int S_WR_OREG = 9;
  localparam int S_RD_OREG = 10;
  localparam int S_RD_MORE = 11;         // Multi-byte drain
  localparam int S_CHK_CNT = 12;         // End-of-input check
  localparam int S_SP_CHR  = 13;
  localparam int S_FLUSH   = 14;
  localparam int S_DONE    = 15;

  logic [15:0] state;
  logic [15:0] nxt;
  logic        done_cr_st;
  logic        recal_st;
  logic        recal_q;
  logic        sp_written;               // Special end code already sent

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= 16'd1 << S_IDLE;
    else
      state <= nxt;
  end

  always_comb
  begin
    nxt = '0;
    hash_cmd = '0;
    oreg_cmd = '0;
    dict_ctl = '0;
    dict_ctl.ena_cvram = 1'b1;           // Port A on except in the sweep
    io_ram = '0;
    out_ram = '0;
    cv_ram = '0;
    inc_io = 1'b0;
    inc_out = 1'b0;
    inc_cv = 1'b0;
    clr_cv = 1'b0;
    inc_code = 1'b0;
    run_done = 1'b0;
    done_cr_st = 1'b0;
    recal_st = 1'b0;
    unique case (1'b1)
      state[S_IDLE]:
      begin
        if (init_cr)
        begin
          cv_ram = '{en: 1'b1, we: 1'b1}; // First sweep write
          inc_cv = 1'b1;
          dict_ctl.ena_cvram = 1'b0;
          nxt[S_INIT_CR] = 1'b1;
        end
        else
          nxt[S_IDLE] = 1'b1;
      end
      state[S_INIT_CR]:
      begin
        if (cv_end)
        begin
          done_cr_st = 1'b1;
          clr_cv = 1'b1;
          nxt[S_WT_LZW] = 1'b1;
        end
        else
        begin
          cv_ram = '{en: 1'b1, we: 1'b1};
          inc_cv = 1'b1;
          dict_ctl.ena_cvram = 1'b0;
          nxt[S_INIT_CR] = 1'b1;
        end
      end
      state[S_WT_LZW]:
      begin
        io_ram.en = init_lzw;            // Fetch first char
        nxt[init_lzw ? S_WT_D1 : S_WT_LZW] = 1'b1;
      end
      state[S_WT_D1]:
      begin
        inc_io = 1'b1;
        hash_cmd.shift_char = 1'b1;
        nxt[S_RD_CHR] = 1'b1;
      end
      state[S_RD_CHR]:
      begin
        io_ram.en = 1'b1;
        nxt[S_WT_D2] = 1'b1;
      end
      state[S_WT_D2]:
      begin
        hash_cmd.gen_hash = 1'b1;
        nxt[S_GEN] = 1'b1;
      end
      state[S_GEN]:
        nxt[S_WT_HASH] = 1'b1;           // Hash lookup in CV RAM
      state[S_WT_HASH], state[S_WT_RH]:
      begin
        if (hash_rsp.not_in_mem)
        begin
          dict_ctl = '{ena_cvram: 1'b1, wea_cvram: 1'b1, wea_acram: 1'b1, wea_pcram: 1'b1};
          inc_code = 1'b1;               // Code written, take next
          nxt[S_WR_OREG] = 1'b1;
        end
        else if (hash_rsp.match)
        begin
          hash_cmd.mux_code_val = 1'b1;
          hash_cmd.shift_char = 1'b1;
          nxt[state[S_WT_HASH] ? S_CHK_CNT : S_RD_CHR] = 1'b1;
        end
        else if (hash_rsp.in_code_mem)
        begin
          hash_cmd.mux_code_val = state[S_WT_HASH]; // Only in first wait
          nxt[S_WR_OREG] = 1'b1;
        end
        else if (hash_rsp.collis)
        begin
          recal_st = 1'b1;
          nxt[state[S_WT_HASH] ? S_WT_RH : S_WT_HASH] = 1'b1; // Ping-pong waits
        end
        else
          nxt = state;                   // Hold current wait
      end
      state[S_WR_OREG]:
      begin
        hash_cmd.mux_code_val = hash_rsp.in_code_mem;
        hash_cmd.shift_char = 1'b1;
        oreg_cmd.write_data = 1'b1;
        nxt[S_RD_OREG] = 1'b1;
      end
      state[S_RD_OREG], state[S_RD_MORE]:
      begin
        if (state[S_RD_OREG] || valid_dcnt)
        begin
          oreg_cmd.read_data = 1'b1;
          out_ram = '{en: 1'b1, we: 1'b1};
          inc_out = 1'b1;
          nxt[S_RD_MORE] = 1'b1;
        end
        else
          nxt[S_CHK_CNT] = 1'b1;
      end
      state[S_CHK_CNT]:
      begin
        if (sp_written)
          nxt[S_FLUSH] = 1'b1;
        else if (io_end)
        begin
          oreg_cmd.write_sp = 1'b1;
          inc_out = hash_rsp.match;      // Skip over pending match byte
          nxt[S_SP_CHR] = 1'b1;
        end
        else
        begin
          inc_io = 1'b1;
          nxt[S_RD_CHR] = 1'b1;
        end
      end
      state[S_SP_CHR]:
        nxt[S_RD_OREG] = 1'b1;           // Drain the special code
      state[S_FLUSH]:
      begin
        if (!tc_outreg)
        begin
          oreg_cmd.read_data = 1'b1;     // Last partial byte
          out_ram = '{en: 1'b1, we: 1'b1};
        end
        nxt[S_DONE] = 1'b1;
      end
      state[S_DONE]:
      begin
        run_done = 1'b1;
        nxt[S_IDLE] = 1'b1;
      end
      default:
        nxt[S_IDLE] = 1'b1;              // Illegal encoding recovery
    endcase
    hash_cmd.recal_hash = recal_q;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done_cr <= 1'b0;
      lzw_done <= 1'b0;
      recal_q <= 1'b0;
    end
    else
    begin
      done_cr <= done_cr_st;
      lzw_done <= run_done;
      recal_q <= recal_st;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sp_written <= 1'b0;
    else if (run_done)
      sp_written <= 1'b0;                // Ready for next run
    else if (oreg_cmd.write_sp)
      sp_written <= 1'b1;
  end

endmodule

`default_nettype wire

/* hw/lzw_io_addr.sv */
// IO RAM read address and output RAM write address counters, with end-of-input detection
`timescale 1ns/1ps
`default_nettype none

module lzw_io_addr
  import lzw_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic [IO_ADDR_W-1:0] char_cnt,  // Characters received
  input  wire logic                 inc_io,
  input  wire logic                 inc_out,
  output logic      [IO_ADDR_W-1:0] io_addr,
  output logic      [IO_ADDR_W-1:0] out_addr,  // Also the output byte count
  output logic                      io_end
);

  // Read pointer into the received characters
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      io_addr <= '0;
    else if (inc_io)
      io_addr <= io_addr + 1'b1;
  end

  // Write pointer into the compressed output
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_addr <= '0;
    else if (inc_out)
      out_addr <= out_addr + 1'b1;
  end

  assign io_end = (io_addr == char_cnt);       // Whole input consumed

endmodule

`default_nettype wire

/* hw/lzw_code_ctr.sv */
// Code value RAM sweep address counter and next free dictionary code counter
`timescale 1ns/1ps
`default_nettype none

module lzw_code_ctr
  import lzw_pkg::*;
#(
  parameter int CV_ADDR_W = 11                 // Code value RAM address width
)
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 inc_cv,    // Sweep step request
  input  wire logic                 clr_cv,    // End of sweep
  input  wire logic                 inc_code,  // Dictionary entry written
  input  wire logic                 run_done,  // Run finished
  output logic      [CV_ADDR_W-1:0] cv_addr,
  output logic                      cv_end,
  output logic      [CODE_W-1:0]    next_code
);

  logic inc_cv_d;                              // Step lags the write by a cycle

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      inc_cv_d <= 1'b0;
    else
      inc_cv_d <= inc_cv;
  end

  // Sweep address, clear wins over step
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cv_addr <= '0;
    else if (clr_cv)
      cv_addr <= '0;
    else if (inc_cv_d)
      cv_addr <= cv_addr + 1'b1;
  end

  assign cv_end = &cv_addr;                    // Last RAM word reached

  // Next free code, restarts after the literals each run
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      next_code <= FIRST_CODE;
    else if (run_done)
      next_code <= FIRST_CODE;
    else if (inc_code)
      next_code <= next_code + 1'b1;
  end

endmodule

`default_nettype wire

/* hw/lzw_ctrl.sv */
// Top of the LZW control unit, joining the sequencer and counters to the RAM, hash and outreg ports
`timescale 1ns/1ps
`default_nettype none

module lzw_ctrl
  import lzw_pkg::*;
#(
  parameter int CV_ADDR_W = 11                 // Code value RAM depth as log2
)
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 init_cr,   // Start CV RAM init
  input  wire logic                 init_lzw,  // Start compression
  input  wire logic [IO_ADDR_W-1:0] char_cnt,
  input  wire hash_rsp_t            hash_rsp,
  input  wire logic                 valid_dcnt,
  input  wire logic                 tc_outreg,
  output logic                      done_cr,
  output logic                      lzw_done,
  output hash_cmd_t                 hash_cmd,
  output oreg_cmd_t                 oreg_cmd,
  output ram_ctl_t                  io_ram,
  output logic      [IO_ADDR_W-1:0] io_addr,
  output ram_ctl_t                  out_ram,
  output logic      [IO_ADDR_W-1:0] out_addr,
  output ram_ctl_t                  cv_ram,
  output logic      [CV_ADDR_W-1:0] cv_addr,
  output dict_wr_t                  dict_wr
);

  dict_en_t          dict_ctl;
  logic              inc_io;
  logic              inc_out;
  logic              inc_cv;
  logic              clr_cv;
  logic              inc_code;
  logic              run_done;
  logic              io_end;
  logic              cv_end;
  logic [CODE_W-1:0] next_code;

  lzw_seq_fsm u_seq (
    .clk, .rst_n, .init_cr, .init_lzw, .hash_rsp, .valid_dcnt, .tc_outreg,
    .io_end, .cv_end, .hash_cmd, .oreg_cmd, .dict_ctl, .io_ram, .out_ram, .cv_ram,
    .inc_io, .inc_out, .inc_cv, .clr_cv, .inc_code, .run_done, .done_cr, .lzw_done
  );

  lzw_io_addr u_io_addr (
    .clk, .rst_n, .char_cnt, .inc_io, .inc_out, .io_addr, .out_addr, .io_end
  );

  lzw_code_ctr #(
    .CV_ADDR_W (CV_ADDR_W)
  ) u_code_ctr (
    .clk, .rst_n, .inc_cv, .clr_cv, .inc_code, .run_done, .cv_addr, .cv_end, .next_code
  );

  assign dict_wr = '{en: dict_ctl, wr_cvdataa: next_code}; // New entry carries next code

endmodule

`default_nettype wire

/* testbench/tb_lzw_ctrl.sv */
// Testbench for the LZW control unit, replays per-cycle vectors and checks the control outputs
`timescale 1ns/1ps
`default_nettype none

module tb_lzw_ctrl
  import lzw_pkg::*;
();

  localparam int CV_W = 4;                       // 16-word CV RAM keeps the sweep short
  localparam int MAX_VEC = 512;

  typedef struct packed {
    int                   test;                  // Test number of the row
    logic                 init_cr;
    logic                 init_lzw;
    logic [IO_ADDR_W-1:0] char_cnt;
    hash_rsp_t            rsp;
    logic                 valid_dcnt;
    logic                 tc_outreg;
    logic                 done_cr;               // Expected from here on
    logic                 lzw_done;
    hash_cmd_t            hash_cmd;
    oreg_cmd_t            oreg_cmd;
    dict_wr_t             dict_wr;
    logic [IO_ADDR_W-1:0] out_addr;
    ram_ctl_t             cv_ram;
  } vec_row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 init_cr;
  logic                 init_lzw;
  logic [IO_ADDR_W-1:0] char_cnt;
  hash_rsp_t            hash_rsp;                // Hash unit stand-in
  logic                 valid_dcnt;              // Output reg stand-in
  logic                 tc_outreg;
  logic                 done_cr;
  logic                 lzw_done;
  hash_cmd_t            hash_cmd;
  oreg_cmd_t            oreg_cmd;
  ram_ctl_t             io_ram;
  logic [IO_ADDR_W-1:0] io_addr;
  ram_ctl_t             out_ram;
  logic [IO_ADDR_W-1:0] out_addr;
  ram_ctl_t             cv_ram;
  logic [CV_W-1:0]      cv_addr;
  dict_wr_t             dict_wr;

  vec_row_t rows [MAX_VEC];
  int       num_vec;
  int       vec_idx;                             // Row under check
  int       errors;
  int       test_errs;                           // Mismatches in current test
  int       tests_pass;
  int       tests_fail;
  int       sweep_k;                             // Cycle of the CV RAM sweep, -1 before it
  int       io_reads;                            // IO RAM reads so far
  logic     lzw_wait;                            // Waiting for init_lzw
  logic     loaded;

  lzw_ctrl #(
    .CV_ADDR_W (CV_W)
  ) u_dut (
    .clk, .rst_n, .init_cr, .init_lzw, .char_cnt, .hash_rsp, .valid_dcnt, .tc_outreg,
    .done_cr, .lzw_done, .hash_cmd, .oreg_cmd, .io_ram, .io_addr, .out_ram, .out_addr,
    .cv_ram, .cv_addr, .dict_wr
  );

  always #2 clk = ~clk;                          // 4 ns period

  task automatic compare(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
    if (act_val !== exp_val)
    begin
      $display("mismatch %s expected %h actual %h at vector %0d",
               name, exp_val, act_val, vec_idx);
      errors++;
      test_errs++;
    end
  endtask

  // Sweep cycle k shows address k - 1, outside the sweep the address rests at 0
  function automatic logic [CV_W-1:0] sweep_addr(input int k);
    if (k < 1 || k > (1 << CV_W))
      return '0;
    else
      return CV_W'(k - 1);
  endfunction

  task automatic load_vectors();
    int       fd;
    int       cnt;
    int       tn, ic, il, cc, rsp, vd, tc;
    int       edc, eld, ehc, eoc, edw, eoa, ecv;
    string    line;
    vec_row_t r;
    fd = $fopen("testbench/lzw_ctrl_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the vector file testbench/lzw_ctrl_vectors.txt");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.len() > 2 && line.substr(0, 1) != "//") // Skip comments and blanks
        begin
          cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tn, ic, il, cc, rsp, vd, tc, edc, eld, ehc, eoc, edw, eoa, ecv);
          if (cnt != 14 || num_vec >= MAX_VEC)
          begin
            $display("vector line after row %0d could not be read", num_vec);
            errors++;
          end
          else
          begin
            r.test = tn;
            r.init_cr = ic[0];
            r.init_lzw = il[0];
            r.char_cnt = cc[IO_ADDR_W-1:0];
            r.rsp = hash_rsp_t'(rsp[3:0]);
            r.valid_dcnt = vd[0];
            r.tc_outreg = tc[0];
            r.done_cr = edc[0];
            r.lzw_done = eld[0];
            r.hash_cmd = hash_cmd_t'(ehc[3:0]);
            r.oreg_cmd = oreg_cmd_t'(eoc[2:0]);
            r.dict_wr = dict_wr_t'(edw[16:0]);  // Enables over code
            r.out_addr = eoa[IO_ADDR_W-1:0];
            r.cv_ram = ram_ctl_t'(ecv[1:0]);
            rows[num_vec] = r;
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_inputs(input vec_row_t r);
    init_cr = r.init_cr;
    init_lzw = r.init_lzw;
    char_cnt = r.char_cnt;
    hash_rsp = r.rsp;
    valid_dcnt = r.valid_dcnt;
    tc_outreg = r.tc_outreg;
  endtask

  task automatic check_outputs(input int i);
    vec_row_t r;
    logic     io_rd;
    r = rows[i];
    if (r.done_cr)
      lzw_wait = 1'b1;                           // done_cr lands in the LZW wait
    io_rd = (lzw_wait && r.init_lzw)
            || (i + 1 < num_vec && rows[i+1].hash_cmd.gen_hash); // Char read before each hash
    compare("done_cr", 32'(r.done_cr), 32'(done_cr));
    compare("lzw_done", 32'(r.lzw_done), 32'(lzw_done));
    compare("hash_cmd", 32'(r.hash_cmd), 32'(hash_cmd));
    compare("oreg_cmd", 32'(r.oreg_cmd), 32'(oreg_cmd));
    compare("dict_wr", 32'(r.dict_wr), 32'(dict_wr));
    compare("out_addr", 32'(r.out_addr), 32'(out_addr));
    compare("cv_ram", 32'(r.cv_ram), 32'(cv_ram));
    compare("out_ram", 32'({2{r.oreg_cmd.read_data}}), 32'(out_ram)); // Each popped byte written
    compare("cv_addr", 32'(sweep_addr(sweep_k)), 32'(cv_addr));
    compare("io_ram", 32'({io_rd, 1'b0}), 32'(io_ram)); // Read only, never written
    if (io_rd)
    begin
      compare("io_addr", 32'(io_reads), 32'(io_addr)); // Chars read in address order
      io_reads++;
    end
    if (r.oreg_cmd.write_sp)
      compare("io_addr", 32'(r.char_cnt), 32'(io_addr)); // End code once input used up
    if (lzw_wait && r.init_lzw)
      lzw_wait = 1'b0;
  endtask

  task automatic report_test(input int num);
    if (test_errs == 0)
    begin
      $display("test %0d pass", num);
      tests_pass++;
    end
    else
    begin
      $display("test %0d fail with %0d mismatches", num, test_errs);
      tests_fail++;
    end
    test_errs = 0;
  endtask

  initial
  begin
    int i;
    clk = 1'b0;
    rst_n = 1'b0;
    init_cr = 1'b0;
    init_lzw = 1'b0;
    char_cnt = '0;
    hash_rsp = '0;
    valid_dcnt = 1'b0;
    tc_outreg = 1'b0;
    num_vec = 0;
    vec_idx = 0;
    errors = 0;
    test_errs = 0;
    tests_pass = 0;
    tests_fail = 0;
    sweep_k = -1;
    io_reads = 0;
    lzw_wait = 1'b0;
    loaded = 1'b0;
    load_vectors();
    loaded = 1'b1;                               // Arms the watchdog
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < num_vec; i++)
    begin
      @(negedge clk);
      apply_inputs(rows[i]);
      #1;                                        // Mid low phase, outputs settled
      if (i > 0 && rows[i].test != rows[i-1].test)
        report_test(rows[i-1].test);
      if (rows[i].init_cr && (sweep_k < 0 || sweep_k > (1 << CV_W)))
        sweep_k = 0;                             // Sweep starts in the init_cr cycle
      else if (sweep_k >= 0)
        sweep_k++;
      vec_idx = i;
      check_outputs(i);
    end
    if (num_vec > 0)
      report_test(rows[num_vec-1].test);
    else
    begin
      $display("no vectors were loaded");
      errors++;
    end
    $display("tests passed %0d failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog, sized from the vector count plus reset margin
  initial
  begin
    wait (loaded);
    #((num_vec + 20) * 4);
    $display("run timed out before all %0d vectors were checked", num_vec);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/lzw_ctrl_vectors.txt */
// test init_cr init_lzw char_cnt hash_rsp valid_dcnt tc_outreg, then expected done_cr lzw_done
// hash_cmd oreg_cmd dict_wr out_addr cv_ram; hex except the test number, one line per cycle
// sweep of the 16-word CV RAM
1 1 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 00100 000 3
1 0 0 005 0 0 0 0 0 0 0 10100 000 0
1 0 0 005 0 0 0 1 0 0 0 10100 000 0
// two new entries, codes 256 and 257
2 0 1 005 0 0 0 0 0 0 0 10100 000 0
2 0 0 005 0 0 0 0 0 2 0 10100 000 0
2 0 0 005 0 0 0 0 0 0 0 10100 000 0
2 0 0 005 0 0 0 0 0 8 0 10100 000 0
2 0 0 005 0 0 0 0 0 0 0 10100 000 0
2 0 0 005 8 0 0 0 0 0 0 1e100 000 0
2 0 0 005 0 0 0 0 0 2 4 10101 000 0
2 0 0 005 0 0 0 0 0 0 2 10101 000 0
2 0 0 005 0 0 0 0 0 0 0 10101 001 0
2 0 0 005 0 0 0 0 0 0 0 10101 001 0
2 0 0 005 0 0 0 0 0 0 0 10101 001 0
2 0 0 005 0 0 0 0 0 8 0 10101 001 0
2 0 0 005 0 0 0 0 0 0 0 10101 001 0
2 0 0 005 8 0 0 0 0 0 0 1e101 001 0
2 0 0 005 0 0 0 0 0 2 4 10102 001 0
2 0 0 005 0 0 0 0 0 0 2 10102 001 0
2 0 0 005 0 0 0 0 0 0 0 10102 002 0
// reuse of a code, then a match
3 0 0 005 0 0 0 0 0 0 0 10102 002 0
3 0 0 005 0 0 0 0 0 0 0 10102 002 0
3 0 0 005 0 0 0 0 0 8 0 10102 002 0
3 0 0 005 0 0 0 0 0 0 0 10102 002 0
3 0 0 005 4 0 0 0 0 1 0 10102 002 0
3 0 0 005 4 0 0 0 0 3 4 10102 002 0
3 0 0 005 0 0 0 0 0 0 2 10102 002 0
3 0 0 005 0 0 0 0 0 0 0 10102 003 0
3 0 0 005 0 0 0 0 0 0 0 10102 003 0
3 0 0 005 0 0 0 0 0 0 0 10102 003 0
3 0 0 005 0 0 0 0 0 8 0 10102 003 0
3 0 0 005 0 0 0 0 0 0 0 10102 003 0
3 0 0 005 2 0 0 0 0 3 0 10102 003 0
3 0 0 005 0 0 0 0 0 0 0 10102 003 0
// collision in both waits, then a new entry
4 0 0 005 0 0 0 0 0 0 0 10102 003 0
4 0 0 005 0 0 0 0 0 8 0 10102 003 0
4 0 0 005 0 0 0 0 0 0 0 10102 003 0
4 0 0 005 1 0 0 0 0 0 0 10102 003 0
4 0 0 005 1 0 0 0 0 4 0 10102 003 0
4 0 0 005 0 0 0 0 0 4 0 10102 003 0
4 0 0 005 8 0 0 0 0 0 0 1e102 003 0
4 0 0 005 0 0 0 0 0 2 4 10103 003 0
// drain of three bytes
5 0 0 005 0 0 0 0 0 0 2 10103 003 0
5 0 0 005 0 1 0 0 0 0 2 10103 004 0
5 0 0 005 0 1 0 0 0 0 2 10103 005 0
5 0 0 005 0 0 0 0 0 0 0 10103 006 0
// end code, drain, flush and done
6 0 0 005 2 0 0 0 0 0 1 10103 006 0
6 0 0 005 0 0 0 0 0 0 0 10103 007 0
6 0 0 005 0 0 0 0 0 0 2 10103 007 0
6 0 0 005 0 1 0 0 0 0 2 10103 008 0
6 0 0 005 0 0 0 0 0 0 0 10103 009 0
6 0 0 005 0 0 0 0 0 0 0 10103 009 0
6 0 0 005 0 0 0 0 0 0 2 10103 009 0
6 0 0 005 0 0 0 0 0 0 0 10103 009 0
6 0 0 005 0 0 0 0 1 0 0 10100 009 0

/* list.f */
hw/lzw_pkg.sv
hw/lzw_seq_fsm.sv
hw/lzw_io_addr.sv
hw/lzw_code_ctr.sv
hw/lzw_ctrl.sv
testbench/tb_lzw_ctrl.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f list.f --top-module tb_lzw_ctrl -Mdir obj_dir -o tb_lzw_ctrl

run: compile
	obj_dir/tb_lzw_ctrl > sim.log 2>&1; cat sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
